//--- Bender.yml
package:
  name: hart_cluster

sources:
  - rtl/hmr_pkg.sv
  - rtl/acc_core.sv
  - rtl/hmr_vote.sv
  - rtl/hmr_regs.sv
  - rtl/hart_cluster.sv
  - target: test
    files:
      - testbench/tb_hart_cluster.sv

//--- rtl/acc_core.sv
/*
 * Accumulator hart
 * Queues credit-fed operation items and emits the accumulator
 * on READ, gated by result credits
 */

module acc_core #(
  parameter int unsigned ItemDepth     = 4,
  parameter int unsigned ResultCredits = 2
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clear_i,
  input  hmr_pkg::core_in_t  core_i,
  output hmr_pkg::core_out_t core_o
);
  import hmr_pkg::*;

  localparam int unsigned PtrW  = (ItemDepth > 1) ? $clog2(ItemDepth) : 1;
  localparam int unsigned CntW  = $clog2(ItemDepth + 1);
  localparam int unsigned CredW = $clog2(ResultCredits + 1);

  op_item_t         fifo_q [ItemDepth];
  logic [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic [CredW-1:0] res_credits_q;
  logic [31:0]      acc_q, acc_d;

  op_item_t head;
  logic     push, pop, emit;
  logic     head_valid, head_is_read;

  logic    result_valid_q, item_credit_q;
  result_t result_q;

  // Sender only drives valid while holding a credit, so no full check
  assign push = core_i.item_valid;

  assign head         = fifo_q[rd_ptr_q];
  assign head_valid   = (count_q != '0);
  assign head_is_read = (head.op == OP_READ);

  // READ waits at the head until a result credit is free
  assign pop  = head_valid && !clear_i && (!head_is_read || (res_credits_q != '0));
  assign emit = pop && head_is_read;

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= core_i.item;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(ItemDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(ItemDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_credits_q <= CredW'(ResultCredits);
    end else begin
      res_credits_q <= res_credits_q + CredW'(core_i.result_credit) - CredW'(emit);
    end
  end

  always_comb begin
    unique case (head.op)
      OP_ADD:  acc_d = acc_q + head.data;
      OP_XOR:  acc_d = acc_q ^ head.data;
      OP_LOAD: acc_d = head.data;
      default: acc_d = acc_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      acc_q <= '0;
    end else if (pop) begin
      acc_q <= acc_d;
    end
  end

  // Result payload is zero when idle so a DMR pair only differs on live data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_q <= 1'b0;
      item_credit_q  <= 1'b0;
      result_q       <= '0;
    end else begin
      result_valid_q <= emit;
      item_credit_q  <= pop;
      result_q       <= emit ? result_t'{hart: core_i.hart_id, data: acc_q} : '0;
    end
  end

  assign core_o = '{
    result_valid: result_valid_q,
    result:       result_q,
    item_credit:  item_credit_q
  };

endmodule

//--- rtl/hart_cluster.sv
/*
 * Hart cluster top level
 * Binds the item and result channels into core bundles and wires
 * the harts through the redundancy unit and its registers
 */

module hart_cluster #(
  parameter int unsigned NumHarts      = 2,
  parameter int unsigned ItemDepth     = 4,
  parameter int unsigned ResultCredits = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic              [NumHarts-1:0]    item_valid_i,
  input  hmr_pkg::op_item_t [NumHarts-1:0]    item_i,
  output logic              [NumHarts-1:0]    item_credit_o,
  output logic              [NumHarts-1:0]    result_valid_o,
  output hmr_pkg::result_t  [NumHarts-1:0]    result_o,
  input  logic              [NumHarts-1:0]    result_credit_i,
  input  hmr_pkg::reg_req_t                   reg_req_i,
  output hmr_pkg::reg_rsp_t                   reg_rsp_o
);
  import hmr_pkg::*;

  core_in_t  [NumHarts-1:0] sys2hmr, hmr2core;
  core_out_t [NumHarts-1:0] hmr2sys, core2hmr;
  logic      [NumHarts-1:0] core_setback;

  logic dmr_en, fault_arm, mismatch, fault_used;

  for (genvar h = 0; h < NumHarts; h++) begin : gen_harts
    // System side into the redundancy unit
    assign sys2hmr[h] = '{
      hart_id:       2'(h),
      item_valid:    item_valid_i[h],
      item:          item_i[h],
      result_credit: result_credit_i[h]
    };

    // Redundancy unit back to the channels
    assign item_credit_o[h]  = hmr2sys[h].item_credit;
    assign result_valid_o[h] = hmr2sys[h].result_valid;
    assign result_o[h]       = hmr2sys[h].result;

    acc_core #(
      .ItemDepth     ( ItemDepth     ),
      .ResultCredits ( ResultCredits )
    ) i_acc_core (
      .clk_i   ( clk_i           ),
      .rst_i   ( rst_i           ),
      .clear_i ( core_setback[h] ),
      .core_i  ( hmr2core[h]     ),
      .core_o  ( core2hmr[h]     )
    );
  end

  hmr_vote #(
    .NumHarts ( NumHarts   ),
    .in_t     ( core_in_t  ),
    .out_t    ( core_out_t )
  ) i_hmr_vote (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .dmr_en_i     ( dmr_en       ),
    .fault_arm_i  ( fault_arm    ),
    .sys_in_i     ( sys2hmr      ),
    .sys_out_o    ( hmr2sys      ),
    .core_in_o    ( hmr2core     ),
    .core_out_i   ( core2hmr     ),
    .setback_o    ( core_setback ),
    .mismatch_o   ( mismatch     ),
    .fault_used_o ( fault_used   )
  );

  hmr_regs i_hmr_regs (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .reg_req_i    ( reg_req_i  ),
    .reg_rsp_o    ( reg_rsp_o  ),
    .mismatch_i   ( mismatch   ),
    .fault_used_i ( fault_used ),
    .dmr_en_o     ( dmr_en     ),
    .fault_arm_o  ( fault_arm  )
  );

endmodule

//--- rtl/hmr_pkg.sv
/*
 * HMR hart cluster package
 * Operation items, tagged results, per-core in/out bundles,
 * register port structs and the register map
 */

package hmr_pkg;

  // Operation codes understood by the accumulator harts
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_XOR  = 2'd1,
    OP_LOAD = 2'd2,
    OP_READ = 2'd3
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] data;
  } op_item_t;

  // Result tagged with the producing hart
  typedef struct packed {
    logic [1:0]  hart;
    logic [31:0] data;
  } result_t;

  // Everything the system hands to one core
  typedef struct packed {
    logic [1:0] hart_id;
    logic       item_valid;
    op_item_t   item;
    logic       result_credit;
  } core_in_t;

  // Everything one core hands back, compared as a whole in DMR mode
  typedef struct packed {
    logic    result_valid;
    result_t result;
    logic    item_credit;
  } core_out_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Register map, byte offsets
  localparam logic [3:0] REG_MODE      = 4'h0;
  localparam logic [3:0] REG_ERR_COUNT = 4'h4;
  localparam logic [3:0] REG_FAULT_INJ = 4'h8;
  localparam logic [3:0] REG_STATUS    = 4'hC;

endpackage

//--- rtl/hmr_regs.sv
/*
 * HMR register block
 * Mode, mismatch counter, sticky status and one-shot fault injection
 */

module hmr_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  input  hmr_pkg::reg_req_t reg_req_i,
  output hmr_pkg::reg_rsp_t reg_rsp_o,
  input  logic              mismatch_i,
  input  logic              fault_used_i,
  output logic              dmr_en_o,
  output logic              fault_arm_o
);
  import hmr_pkg::*;

  logic        mode_q;
  logic [31:0] err_count_q;
  logic        fault_arm_q;
  logic        status_q;

  logic        wr_en;
  logic [31:0] rdata;

  logic        rsp_valid_q;
  logic [31:0] rsp_rdata_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_q      <= 1'b0;
      err_count_q <= '0;
      fault_arm_q <= 1'b0;
      status_q    <= 1'b0;
    end else begin
      if (wr_en && reg_req_i.addr == REG_MODE) begin
        mode_q <= reg_req_i.wdata[0];
      end

      // Any write clears, a mismatch in the same cycle still counts
      if (wr_en && reg_req_i.addr == REG_ERR_COUNT) begin
        err_count_q <= 32'(mismatch_i);
      end else begin
        err_count_q <= err_count_q + 32'(mismatch_i);
      end

      if (wr_en && reg_req_i.addr == REG_FAULT_INJ && reg_req_i.wdata[0]) begin
        fault_arm_q <= 1'b1;
      end else if (fault_used_i) begin
        fault_arm_q <= 1'b0;
      end

      // Sticky flag, a new mismatch wins over a clear
      if (mismatch_i) begin
        status_q <= 1'b1;
      end else if (wr_en && reg_req_i.addr == REG_STATUS && reg_req_i.wdata[0]) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    unique case (reg_req_i.addr)
      REG_MODE:      rdata = {31'b0, mode_q};
      REG_ERR_COUNT: rdata = err_count_q;
      REG_FAULT_INJ: rdata = {31'b0, fault_arm_q};
      REG_STATUS:    rdata = {31'b0, status_q};
      default:       rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_req_i.valid;
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    if (reg_req_i.valid) begin
      rsp_rdata_q <= reg_req_i.write ? '0 : rdata;
    end
  end

  assign reg_rsp_o   = '{valid: rsp_valid_q, rdata: rsp_rdata_q};
  assign dmr_en_o    = mode_q;
  assign fault_arm_o = fault_arm_q;

endmodule

//--- rtl/hmr_vote.sv
/*
 * Redundancy unit
 * Routes system and core bundles per mode, pairs harts in DMR,
 * compares pair outputs and raises setback on a mismatch
 */

module hmr_vote #(
  parameter int unsigned NumHarts = 2,
  parameter type         in_t     = hmr_pkg::core_in_t,
  parameter type         out_t    = hmr_pkg::core_out_t
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                dmr_en_i,
  input  logic                fault_arm_i,
  input  in_t  [NumHarts-1:0] sys_in_i,
  output out_t [NumHarts-1:0] sys_out_o,
  output in_t  [NumHarts-1:0] core_in_o,
  input  out_t [NumHarts-1:0] core_out_i,
  output logic [NumHarts-1:0] setback_o,
  output logic                mismatch_o,
  output logic                fault_used_o
);

  localparam int unsigned NumPairs = NumHarts / 2;

  logic [NumPairs-1:0] pair_mismatch;
  logic [NumPairs-1:0] flip;
  logic                fault_done_q;
  logic                flip_en;

  // One flip per arming, even if the arm bit is still high next cycle
  assign flip_en = fault_arm_i && !fault_done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fault_done_q <= 1'b0;
    end else begin
      fault_done_q <= fault_arm_i && (fault_done_q || fault_used_o);
    end
  end

  for (genvar p = 0; p < NumPairs; p++) begin : gen_pairs
    // Whole-struct compare of the registered core outputs
    assign pair_mismatch[p] = dmr_en_i && (core_out_i[2*p] != core_out_i[2*p+1]);

    assign setback_o[2*p]   = pair_mismatch[p];
    assign setback_o[2*p+1] = pair_mismatch[p];

    // Flip lands on the first leader item seen while armed
    assign flip[p] = flip_en && dmr_en_i && sys_in_i[2*p].item_valid;
  end

  assign mismatch_o   = |pair_mismatch;
  assign fault_used_o = |flip;

  always_comb begin
    core_in_o = sys_in_i;
    sys_out_o = core_out_i;
    if (dmr_en_i) begin
      for (int p = 0; p < NumPairs; p++) begin
        // Follower runs on the leader's inputs, hart_id included
        core_in_o[2*p+1] = sys_in_i[2*p];
        if (flip[p]) begin
          core_in_o[2*p+1].item.data[0] = ~sys_in_i[2*p].item.data[0];
        end
        // Follower channel stays silent
        sys_out_o[2*p+1] = '0;
      end
    end
  end

endmodule

//--- tb.f
rtl/hmr_pkg.sv
rtl/acc_core.sv
rtl/hmr_vote.sv
rtl/hmr_regs.sv
rtl/hart_cluster.sv
testbench/tb_hart_cluster.sv

//--- testbench/tb_hart_cluster.sv
/*
 * Testbench for the HMR hart cluster
 * LFSR driven item traffic against an accumulator model, plus DMR,
 * fault injection and register checks through the register port
 */

module tb_hart_cluster;
  timeunit 1ns;
  timeprecision 1ns;
  import hmr_pkg::*;

  localparam int NumHarts      = 2;
  localparam int ItemDepth     = 4;
  localparam int ResultCredits = 2;
  localparam int Timeout       = 1000;

  logic                    clk;
  logic                    rst;
  logic     [NumHarts-1:0] item_valid;
  logic     [NumHarts-1:0] item_credit;
  logic     [NumHarts-1:0] result_valid;
  logic     [NumHarts-1:0] result_credit;
  op_item_t [NumHarts-1:0] item;
  result_t  [NumHarts-1:0] result;
  reg_req_t                reg_req;
  reg_req_t                reg_next;
  reg_rsp_t                reg_rsp;

  // Model and per-channel bookkeeping
  logic [31:0] lfsr_q;
  logic [31:0] acc_model [NumHarts];
  result_t     exp_q [NumHarts][$];
  int          credits [NumHarts];
  int          pulses [NumHarts];
  int          sent [NumHarts];
  int          seen [NumHarts];
  int          owed [NumHarts];
  logic        hold;
  logic        fixed_en;
  op_item_t    fixed_item;
  string       cur_test;
  int          errors;
  int          err_base;
  int          tests;
  int          failed_tests;

  hart_cluster #(
    .NumHarts      ( NumHarts      ),
    .ItemDepth     ( ItemDepth     ),
    .ResultCredits ( ResultCredits )
  ) u_hart_cluster (
    .clk_i           ( clk           ),
    .rst_i           ( rst           ),
    .item_valid_i    ( item_valid    ),
    .item_i          ( item          ),
    .item_credit_o   ( item_credit   ),
    .result_valid_o  ( result_valid  ),
    .result_o        ( result        ),
    .result_credit_i ( result_credit ),
    .reg_req_i       ( reg_req       ),
    .reg_rsp_o       ( reg_rsp       )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_result(input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", cur_test, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s (%s): expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_credits(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("error %s (%s): expected %0d actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", cur_test, errors - err_base);
    end
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d failing, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout in test %s: %s", cur_test, what);
    errors++;
  endtask

  // Accumulator rules, READ queues the current value with the channel tag
  function automatic void apply_model(input int h, input op_item_t it);
    case (it.op)
      OP_ADD:  acc_model[h] = acc_model[h] + it.data;
      OP_XOR:  acc_model[h] = acc_model[h] ^ it.data;
      OP_LOAD: acc_model[h] = it.data;
      default: exp_q[h].push_back('{hart: 2'(h), data: acc_model[h]});
    endcase
  endfunction

  // One clock of stimulus, items only while a credit is held
  task automatic tick(input logic [NumHarts-1:0] send_mask);
    op_item_t            it;
    logic [1:0]          opc;
    logic [NumHarts-1:0] valid;
    logic [NumHarts-1:0] rcred;
    @(posedge clk);
    valid = '0;
    rcred = '0;
    for (int h = 0; h < NumHarts; h++) begin
      if (credits[h] > 0) begin
        if (fixed_en && h == 0) begin
          it = fixed_item;
          fixed_en = 1'b0;
          valid[h] = 1'b1;
        end else if (send_mask[h] && rand_bits(1)) begin
          opc = 2'(rand_bits(2));
          it.op = op_e'(opc);
          it.data = rand_bits(32);
          valid[h] = 1'b1;
        end
      end
      if (valid[h]) begin
        apply_model(h, it);
        credits[h]--;
        sent[h]++;
        item[h] <= it;
      end
      if (!hold && owed[h] > 0 && rand_bits(1)) begin
        rcred[h] = 1'b1;
        owed[h]--;
      end
    end
    item_valid    <= valid;
    result_credit <= rcred;
    reg_req       <= reg_next;
    reg_next = '0;
  endtask

  task automatic stream(input logic [NumHarts-1:0] mask, input int cycles);
    repeat (cycles) tick(mask);
  endtask

  task automatic drain();
    int i;
    for (i = 0; i < Timeout; i++) begin
      tick('0);
      if (exp_q[0].size() == 0 && exp_q[1].size() == 0 && credits[0] == ItemDepth &&
          credits[1] == ItemDepth && owed[0] == 0 && owed[1] == 0) break;
    end
    if (i == Timeout) timeout_fail("traffic did not drain");
  endtask

  task automatic send_one(input op_e op, input logic [31:0] data);
    int i;
    fixed_item = '{op: op, data: data};
    fixed_en = 1'b1;
    for (i = 0; i < Timeout && fixed_en; i++) begin
      tick('0);
    end
    if (fixed_en) begin
      fixed_en = 1'b0;
      timeout_fail("no item credit on channel 0");
    end
  endtask

  task automatic reg_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int i;
    reg_next = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    for (i = 0; i < Timeout; i++) begin
      tick('0);
      @(negedge clk);
      if (reg_rsp.valid) break;
    end
    if (i == Timeout) timeout_fail("no register response");
    rdata = reg_rsp.rdata;
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic check_read(input string what, input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    reg_access(1'b0, addr, '0, rd);
    check_reg(what, exp, rd);
  endtask

  // Outputs are registered, sample them away from the driving edge
  always @(negedge clk) begin
    for (int h = 0; h < NumHarts; h++) begin
      if (item_credit[h] === 1'b1) begin
        credits[h]++;
        pulses[h]++;
        if (credits[h] > ItemDepth) begin
          $display("item credit returned beyond FIFO depth on channel %0d", h);
          errors++;
        end
      end
      if (result_valid[h] === 1'b1) begin
        seen[h]++;
        owed[h]++;
        if (exp_q[h].size() == 0) begin
          $display("unexpected result on channel %0d in test %s", h, cur_test);
          errors++;
        end else begin
          check_result(exp_q[h].pop_front(), result[h]);
        end
      end
    end
  end

  initial begin
    int base;
    lfsr_q = 32'h2a7168fe;
    rst = 1'b1;
    item_valid = '0;
    item = '0;
    result_credit = '0;
    reg_req = '0;
    reg_next = '0;
    hold = 1'b0;
    fixed_en = 1'b0;
    fixed_item = '0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    cur_test = "reset";
    for (int h = 0; h < NumHarts; h++) begin
      credits[h] = ItemDepth;
      pulses[h] = 0;
      sent[h] = 0;
      seen[h] = 0;
      owed[h] = 0;
      acc_model[h] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset_state");
    repeat (5) tick('0);
    check_credits("credit pulses", 0, pulses[0] + pulses[1]);
    check_credits("results", 0, seen[0] + seen[1]);
    check_read("MODE", REG_MODE, '0);
    check_read("ERR_COUNT", REG_ERR_COUNT, '0);
    check_read("FAULT_INJ", REG_FAULT_INJ, '0);
    check_read("STATUS", REG_STATUS, '0);
    end_test();

    begin_test("independent");
    stream(2'b11, 300);
    drain();
    end_test();

    // Two READs can leave, the rest wait at the FIFO head
    begin_test("credits");
    base = seen[0];
    hold = 1'b1;
    repeat (ResultCredits + 2) send_one(OP_READ, '0);
    repeat (20) tick('0);
    check_credits("results while held", ResultCredits, seen[0] - base);
    check_credits("item credits while held", ItemDepth - 2, credits[0]);
    hold = 1'b0;
    drain();
    check_credits("channel 0 credit pulses", sent[0], pulses[0]);
    check_credits("channel 1 credit pulses", sent[1], pulses[1]);
    end_test();

    // A LOAD first so both harts of the pair agree
    begin_test("dmr");
    base = seen[1];
    reg_write(REG_MODE, 32'h1);
    send_one(OP_LOAD, rand_bits(32));
    stream(2'b01, 200);
    drain();
    check_credits("channel 1 results", base, seen[1]);
    check_read("ERR_COUNT", REG_ERR_COUNT, '0);
    end_test();

    begin_test("fault_injection");
    reg_write(REG_FAULT_INJ, 32'h1);
    send_one(OP_LOAD, rand_bits(32));
    send_one(OP_READ, '0);
    drain();
    // Setback cleared both accumulators
    acc_model[0] = '0;
    acc_model[1] = '0;
    check_read("ERR_COUNT", REG_ERR_COUNT, 32'h1);
    check_read("STATUS", REG_STATUS, 32'h1);
    check_read("FAULT_INJ", REG_FAULT_INJ, '0);
    send_one(OP_READ, '0);
    drain();
    end_test();

    begin_test("register_clears");
    reg_write(REG_ERR_COUNT, 32'h5);
    check_read("ERR_COUNT", REG_ERR_COUNT, '0);
    reg_write(REG_STATUS, 32'h1);
    check_read("STATUS", REG_STATUS, '0);
    check_read("unmapped", 4'h2, '0);
    end_test();

    finish_run();
  end

endmodule
